/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = div_tb
FILELIST = flist.f
BUILD    = obj_dir
LOG      = sim.log
SIM      = $(BUILD)/V$(TOP)

.PHONY: all compile run check clean

all: check

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-$(SIM) > $(LOG) 2>&1
	cat $(LOG)

check: run
	@if grep -q "Regression passed" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* design/div_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module div_ctrl import div_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  div_cmd_t    cmd_i,
    input  logic        divisor_zero_i,
    output logic        load_o,
    output logic        step_o,
    output logic        fix_o,
    output logic        signed_o,
    output div_status_t status_o
);

    div_state_e state_q;
    step_cnt_t  cnt_q;
    logic       signed_q;
    logic       dbz_q;
    logic       can_start;
    logic       last_step;

    // a new division may begin from idle or after the previous one finished
    assign can_start = (state_q == ST_IDLE) || (state_q == ST_DONE);
    assign load_o    = cmd_i.start && !cmd_i.abort && can_start;
    assign step_o    = (state_q == ST_RUN) && !cmd_i.abort;
    assign fix_o     = (state_q == ST_FIX) && !cmd_i.abort;
    assign last_step = cnt_q == step_cnt_t'(DIV_STEPS - 1);

    // the sign mode is needed in the load cycle, before it is latched
    assign signed_o = load_o ? cmd_i.signed_op : signed_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            cnt_q    <= '0;
            signed_q <= 1'b0;
            dbz_q    <= 1'b0;
        end else if (cmd_i.abort) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            dbz_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    if (load_o) begin
                        signed_q <= cmd_i.signed_op;
                        dbz_q    <= divisor_zero_i;
                        cnt_q    <= '0;
                        // a zero divisor skips the iteration entirely
                        state_q  <= divisor_zero_i ? ST_FIX : ST_RUN;
                    end
                end
                ST_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= ST_FIX;
                    end
                end
                ST_FIX: begin
                    state_q <= ST_DONE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign status_o.busy = (state_q == ST_RUN) || (state_q == ST_FIX);
    assign status_o.done = state_q == ST_DONE;
    assign status_o.dbz  = dbz_q;

endmodule

`default_nettype wire

/* design/div_iter.sv */
`timescale 1ns/1ps
`default_nettype none

module div_iter import div_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  load_i,
    input  logic  step_i,
    input  word_t mag_dividend_i,
    input  word_t mag_divisor_i,
    output word_t quot_o,
    output word_t rem_o
);

    acc_t        acc_q;
    acc_t        shifted;
    word_t       divisor_q;
    logic [32:0] diff;

    // **************************************************
    // one restoring step
    // **************************************************

    // bring the next dividend bit into the partial remainder
    assign shifted = {acc_q[63:0], 1'b0};
    assign diff    = shifted[64:32] - {1'b0, divisor_q};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q     <= '0;
            divisor_q <= '0;
        end else if (load_i) begin
            acc_q     <= {33'b0, mag_dividend_i};
            divisor_q <= mag_divisor_i;
        end else if (step_i) begin
            if (diff[32]) begin
                // divisor did not fit, keep the remainder and shift in a zero
                acc_q <= shifted;
            end else begin
                acc_q <= {diff, shifted[31:1], 1'b1};
            end
        end
    end

    assign quot_o = acc_q[31:0];
    assign rem_o  = acc_q[63:32];

endmodule

`default_nettype wire

/* design/div_pkg.sv */
`default_nettype none

package div_pkg;

    // **************************************************
    // widths
    // **************************************************
    typedef logic [31:0] word_t;
    typedef logic [2:0]  wb_addr_t;
    // upper 33 bits hold the partial remainder, lower 32 collect the quotient
    typedef logic [64:0] acc_t;
    typedef logic [5:0]  step_cnt_t;

    localparam int DIV_STEPS = 32;

    // **************************************************
    // register map
    // **************************************************
    localparam wb_addr_t ADDR_DIVIDEND  = 3'd0;
    localparam wb_addr_t ADDR_DIVISOR   = 3'd1;
    localparam wb_addr_t ADDR_CTRL      = 3'd2;
    localparam wb_addr_t ADDR_STATUS    = 3'd3;
    localparam wb_addr_t ADDR_QUOTIENT  = 3'd4;
    localparam wb_addr_t ADDR_REMAINDER = 3'd5;

    localparam int CTRL_START  = 0;
    localparam int CTRL_SIGNED = 1;
    localparam int CTRL_ABORT  = 2;

    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_DBZ  = 2;

    // **************************************************
    // control and datapath types
    // **************************************************
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_FIX,
        ST_DONE
    } div_state_e;

    typedef struct packed {
        logic start;
        logic abort;
        logic signed_op;
    } div_cmd_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic dbz;
    } div_status_t;

    typedef struct packed {
        word_t quotient;
        word_t remainder;
    } div_result_t;

endpackage

`default_nettype wire

/* design/div_sign_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_sign_unit import div_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  word_t       dividend_i,
    input  word_t       divisor_i,
    input  logic        load_i,
    input  logic        fix_i,
    input  logic        signed_i,
    input  logic        dbz_i,
    output logic        divisor_zero_o,
    output word_t       mag_dividend_o,
    output word_t       mag_divisor_o,
    input  word_t       raw_quot_i,
    input  word_t       raw_rem_i,
    output div_result_t result_o
);

    logic        dvd_neg;
    logic        dvs_neg;
    logic        dvd_neg_q;
    logic        quot_neg_q;
    word_t       quot_fixed;
    word_t       rem_fixed;
    div_result_t result_q;

    assign divisor_zero_o = divisor_i == '0;

    assign dvd_neg = signed_i && dividend_i[31];
    assign dvs_neg = signed_i && divisor_i[31];

    // -2^31 maps onto itself, which is the right unsigned magnitude
    assign mag_dividend_o = dvd_neg ? (~dividend_i + 1'b1) : dividend_i;
    assign mag_divisor_o  = dvs_neg ? (~divisor_i + 1'b1) : divisor_i;

    // quotient truncates toward zero, remainder follows the dividend's sign
    assign quot_fixed = quot_neg_q ? (~raw_quot_i + 1'b1) : raw_quot_i;
    assign rem_fixed  = dvd_neg_q ? (~raw_rem_i + 1'b1) : raw_rem_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dvd_neg_q  <= 1'b0;
            quot_neg_q <= 1'b0;
            result_q   <= '0;
        end else begin
            if (load_i) begin
                dvd_neg_q  <= dvd_neg;
                quot_neg_q <= dvd_neg ^ dvs_neg;
            end
            if (fix_i) begin
                if (dbz_i) begin
                    result_q <= '0;
                end else begin
                    result_q.quotient  <= quot_fixed;
                    result_q.remainder <= rem_fixed;
                end
            end
        end
    end

    assign result_o = result_q;

endmodule

`default_nettype wire

/* design/div_top.sv */
`timescale 1ns/1ps
`default_nettype none

module div_top import div_pkg::*; #(
    parameter int WB_ADDR_W = 3
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADDR_W-1:0] wb_adr_i,
    input  word_t                wb_dat_i,
    input  logic [3:0]           wb_sel_i,
    output word_t                wb_dat_o,
    output logic                 wb_ack_o
);

    word_t       dividend;
    word_t       divisor;
    div_cmd_t    cmd;
    div_status_t status;
    div_result_t result;
    logic        load;
    logic        step;
    logic        fix;
    logic        signed_op;
    logic        divisor_zero;
    word_t       mag_dividend;
    word_t       mag_divisor;
    word_t       raw_quot;
    word_t       raw_rem;

    div_wb_regs #(
        .WB_ADDR_W(WB_ADDR_W)
    ) div_wb_regs_inst (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .dividend_o(dividend),
        .divisor_o (divisor),
        .cmd_o     (cmd),
        .status_i  (status),
        .result_i  (result)
    );

    div_ctrl div_ctrl_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cmd_i         (cmd),
        .divisor_zero_i(divisor_zero),
        .load_o        (load),
        .step_o        (step),
        .fix_o         (fix),
        .signed_o      (signed_op),
        .status_o      (status)
    );

    div_sign_unit div_sign_unit_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .dividend_i    (dividend),
        .divisor_i     (divisor),
        .load_i        (load),
        .fix_i         (fix),
        .signed_i      (signed_op),
        .dbz_i         (status.dbz),
        .divisor_zero_o(divisor_zero),
        .mag_dividend_o(mag_dividend),
        .mag_divisor_o (mag_divisor),
        .raw_quot_i    (raw_quot),
        .raw_rem_i     (raw_rem),
        .result_o      (result)
    );

    div_iter div_iter_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .load_i        (load),
        .step_i        (step),
        .mag_dividend_i(mag_dividend),
        .mag_divisor_i (mag_divisor),
        .quot_o        (raw_quot),
        .rem_o         (raw_rem)
    );

endmodule

`default_nettype wire

/* design/div_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module div_wb_regs import div_pkg::*; #(
    parameter int WB_ADDR_W = 3
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADDR_W-1:0] wb_adr_i,
    input  word_t                wb_dat_i,
    // only whole-word access is supported, byte selects are not decoded
    input  logic [3:0]           wb_sel_i,
    output word_t                wb_dat_o,
    output logic                 wb_ack_o,
    output word_t                dividend_o,
    output word_t                divisor_o,
    output div_cmd_t             cmd_o,
    input  div_status_t          status_i,
    input  div_result_t          result_i
);

    logic     req;
    logic     addr_ok;
    wb_addr_t addr;
    word_t    status_word;
    word_t    rd_data;
    logic     ack_q;
    word_t    dat_q;
    word_t    dividend_q;
    word_t    divisor_q;
    div_cmd_t cmd_q;

    // a new request is only taken while no ack is out, so one request gets one ack
    assign req     = wb_cyc_i && wb_stb_i && !ack_q;
    assign addr    = wb_addr_t'(wb_adr_i[2:0]);
    assign addr_ok = (wb_adr_i >> 3) == '0;

    always_comb begin
        status_word            = '0;
        status_word[STAT_BUSY] = status_i.busy;
        status_word[STAT_DONE] = status_i.done;
        status_word[STAT_DBZ]  = status_i.dbz;
    end

    always_comb begin
        rd_data = '0;
        if (addr_ok) begin
            case (addr)
                ADDR_DIVIDEND:  rd_data = dividend_q;
                ADDR_DIVISOR:   rd_data = divisor_q;
                ADDR_STATUS:    rd_data = status_word;
                ADDR_QUOTIENT:  rd_data = result_i.quotient;
                ADDR_REMAINDER: rd_data = result_i.remainder;
                default:        rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            dat_q      <= '0;
            dividend_q <= '0;
            divisor_q  <= '0;
            cmd_q      <= '0;
        end else begin
            ack_q       <= req;
            cmd_q.start <= 1'b0;
            cmd_q.abort <= 1'b0;
            if (req) begin
                dat_q <= wb_we_i ? '0 : rd_data;
                if (wb_we_i && addr_ok) begin
                    case (addr)
                        ADDR_DIVIDEND: dividend_q <= wb_dat_i;
                        ADDR_DIVISOR:  divisor_q  <= wb_dat_i;
                        ADDR_CTRL: begin
                            // abort takes priority over a start in the same word
                            cmd_q.abort     <= wb_dat_i[CTRL_ABORT];
                            cmd_q.start     <= wb_dat_i[CTRL_START] && !wb_dat_i[CTRL_ABORT];
                            cmd_q.signed_op <= wb_dat_i[CTRL_SIGNED];
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    assign wb_ack_o   = ack_q;
    assign wb_dat_o   = dat_q;
    assign dividend_o = dividend_q;
    assign divisor_o  = divisor_q;
    assign cmd_o      = cmd_q;

endmodule

`default_nettype wire

/* flist.f */
design/div_pkg.sv
design/div_wb_regs.sv
design/div_ctrl.sv
design/div_sign_unit.sv
design/div_iter.sv
design/div_top.sv
tests/tb_clkgen.sv
tests/div_properties.sv
tests/div_tb.sv

/* tests/div_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module div_properties import div_pkg::*; (
    input logic        clk,
    input logic        rst_n_i,
    input logic        wb_cyc_i,
    input logic        wb_stb_i,
    input logic        wb_ack_i,
    input div_cmd_t    cmd_i,
    input div_status_t status_i
);

    logic [6:0] busy_cycles;

    // length of the current busy stretch
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_cycles <= '0;
        end else if (status_i.busy) begin
            busy_cycles <= busy_cycles + 7'd1;
        end else begin
            busy_cycles <= '0;
        end
    end

    // **************************************************
    // bus
    // **************************************************
    ack_follows_request: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
        else $error("ack without a request in the cycle before");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_ack_i |=> !wb_ack_i)
        else $error("ack held for more than one cycle");

    // **************************************************
    // controller
    // **************************************************
    busy_done_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(status_i.busy && status_i.done))
        else $error("busy and done high together");

    // done must follow within 36 cycles, so busy may last at most 35
    busy_bounded: assert property (@(posedge clk) disable iff (!rst_n_i)
        busy_cycles <= 7'd35)
        else $error("division still busy after 35 cycles");

    // only an abort may end a division without done
    busy_ends_in_done: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(status_i.busy) |-> status_i.done || $past(cmd_i.abort))
        else $error("busy fell without done and without an abort");

endmodule

`default_nettype wire

/* tests/div_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module div_tb import div_pkg::*; ();

    localparam int CLK_PERIOD_NS = 8;
    localparam int SEED          = 71817;
    localparam int ACK_LIMIT     = 4;
    localparam int POLL_LIMIT    = 40;
    // about 120 divisions run, each gets a budget of 200 clock cycles
    localparam int DIVISIONS           = 125;
    localparam int CYCLES_PER_DIVISION = 200;
    localparam int WATCHDOG_NS = DIVISIONS * CYCLES_PER_DIVISION * CLK_PERIOD_NS;

    logic       clk;
    logic       rst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    word_t      wb_dat_w;
    logic [3:0] wb_sel;
    word_t      wb_dat_r;
    logic       wb_ack;

    tb_clkgen #(
        .PERIOD_NS   (CLK_PERIOD_NS),
        .RESET_CYCLES(8)
    ) tb_clkgen_inst (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    div_top #(
        .WB_ADDR_W(3)
    ) div_top_inst (
        .clk     (clk),
        .rst_n_i (rst_n),
        .wb_cyc_i(wb_cyc),
        .wb_stb_i(wb_stb),
        .wb_we_i (wb_we),
        .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w),
        .wb_sel_i(wb_sel),
        .wb_dat_o(wb_dat_r),
        .wb_ack_o(wb_ack)
    );

    bind div_top div_properties div_properties_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_cyc_i(wb_cyc_i),
        .wb_stb_i(wb_stb_i),
        .wb_ack_i(wb_ack_o),
        .cmd_i   (cmd),
        .status_i(status)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        assert (got === exp)
        else stop_with_failure($sformatf("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h",
                                         $time, what, got, exp));
    endtask

    // **************************************************
    // bus access
    // **************************************************
    task automatic wait_ack();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wb_ack) begin
            cycles++;
            if (cycles > ACK_LIMIT) begin
                stop_with_failure("the DUT gave no ack within 4 cycles of a bus request");
            end
            @(negedge clk);
        end
    endtask

    task automatic wb_write(input wb_addr_t addr, input word_t data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t addr, output word_t data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        wait_ack();
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // **************************************************
    // reference model and division helpers
    // **************************************************
    task automatic expected_result(input word_t a, input word_t b, input logic sgn,
                                   output word_t q, output word_t r);
        longint sa;
        longint sb;
        if (b == '0) begin
            q = '0;
            r = '0;
        end else if (!sgn) begin
            q = a / b;
            r = a % b;
        end else begin
            // 64-bit math truncates toward zero, so -2^31 / -1 wraps to 0x80000000
            sa = longint'($signed(a));
            sb = longint'($signed(b));
            q  = word_t'(sa / sb);
            r  = word_t'(sa % sb);
        end
    endtask

    task automatic start_div(input word_t a, input word_t b, input logic sgn);
        word_t ctrl;
        ctrl              = '0;
        ctrl[CTRL_START]  = 1'b1;
        ctrl[CTRL_SIGNED] = sgn;
        wb_write(ADDR_DIVIDEND, a);
        wb_write(ADDR_DIVISOR, b);
        wb_write(ADDR_CTRL, ctrl);
    endtask

    task automatic wait_done(output word_t status);
        int polls;
        polls = 0;
        wb_read(ADDR_STATUS, status);
        while (!status[STAT_DONE]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                stop_with_failure("the done bit did not come up within 40 status reads");
            end
            wb_read(ADDR_STATUS, status);
        end
    endtask

    task automatic finish_div(input word_t a, input word_t b, input logic sgn);
        word_t status;
        word_t exp_status;
        word_t q;
        word_t r;
        word_t exp_q;
        word_t exp_r;
        wait_done(status);
        expected_result(a, b, sgn, exp_q, exp_r);
        exp_status            = '0;
        exp_status[STAT_DONE] = 1'b1;
        exp_status[STAT_DBZ]  = b == '0;
        check_value("status at done", status, exp_status);
        wb_read(ADDR_QUOTIENT, q);
        check_value($sformatf("quotient of %08h / %08h (signed %0b)", a, b, sgn), q, exp_q);
        wb_read(ADDR_REMAINDER, r);
        check_value($sformatf("remainder of %08h / %08h (signed %0b)", a, b, sgn), r, exp_r);
    endtask

    task automatic run_div(input word_t a, input word_t b, input logic sgn);
        start_div(a, b, sgn);
        finish_div(a, b, sgn);
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic test_reset_values();
        word_t data;
        wb_read(ADDR_STATUS, data);
        check_value("status after reset", data, '0);
        wb_read(ADDR_QUOTIENT, data);
        check_value("quotient after reset", data, '0);
        wb_read(ADDR_REMAINDER, data);
        check_value("remainder after reset", data, '0);
        wb_read(ADDR_DIVIDEND, data);
        check_value("dividend after reset", data, '0);
        wb_write(wb_addr_t'(7), 32'hDEAD_BEEF);
        wb_read(wb_addr_t'(7), data);
        check_value("unused address 7", data, '0);
        wb_read(wb_addr_t'(6), data);
        check_value("unused address 6", data, '0);
    endtask

    task automatic test_unsigned();
        word_t a;
        word_t b;
        run_div(32'd7, 32'd2, 1'b0);
        run_div(32'hFFFF_FFFF, 32'd1, 1'b0);
        run_div(32'd5, 32'd9, 1'b0);
        repeat (50) begin
            a = $urandom();
            b = $urandom() >> ($urandom() % 32);
            run_div(a, b, 1'b0);
        end
    endtask

    task automatic test_signed();
        word_t a;
        word_t b;
        run_div(32'd7, 32'hFFFF_FFFE, 1'b1);
        run_div(32'hFFFF_FFF9, 32'd2, 1'b1);
        run_div(32'hFFFF_FFF9, 32'hFFFF_FFFE, 1'b1);
        run_div(32'd7, 32'd2, 1'b1);
        run_div(32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
        repeat (50) begin
            a = $urandom();
            b = $urandom() >> ($urandom() % 32);
            run_div(a, b, 1'b1);
        end
    endtask

    task automatic test_div_by_zero();
        run_div(32'd1234, 32'd0, 1'b0);
        run_div(32'hFFFF_FFFB, 32'd0, 1'b1);
        // the status check on this one expects dbz to be low again
        run_div(32'd100, 32'd7, 1'b0);
    endtask

    task automatic test_abort();
        word_t data;
        word_t busy_word;
        word_t abort_word;
        word_t exp_q;
        word_t exp_r;
        busy_word              = '0;
        busy_word[STAT_BUSY]   = 1'b1;
        abort_word             = '0;
        abort_word[CTRL_ABORT] = 1'b1;
        run_div(32'd1000, 32'd7, 1'b0);
        expected_result(32'd1000, 32'd7, 1'b0, exp_q, exp_r);
        start_div(32'd50000, 32'd3, 1'b0);
        wb_read(ADDR_STATUS, data);
        check_value("status while running", data, busy_word);
        wb_write(ADDR_CTRL, abort_word);
        wb_read(ADDR_STATUS, data);
        check_value("status after abort", data, '0);
        wb_read(ADDR_QUOTIENT, data);
        check_value("quotient kept over abort", data, exp_q);
        wb_read(ADDR_REMAINDER, data);
        check_value("remainder kept over abort", data, exp_r);
        // the second start lands while the first division runs and must be ignored
        start_div(32'h1234_5678, 32'h0000_1234, 1'b0);
        start_div(32'hFFFF_FF9C, 32'd3, 1'b1);
        finish_div(32'h1234_5678, 32'h0000_1234, 1'b0);
        run_div(32'd9, 32'd3, 1'b0);
    endtask

    initial begin
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'hF;
        void'($urandom(SEED));
        @(posedge rst_n);
        @(posedge clk);
        test_reset_values();
        test_unsigned();
        test_signed();
        test_div_by_zero();
        test_abort();
        $display("Regression passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("the watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

/* tests/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset is released on a rising edge once the reset cycles have passed
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire
